/* logic/smc_mac_pkg.sv */
/* multiple access controller shared types
   size codes, data and counter widths, request and access state structs */

`default_nettype none

package smc_mac_pkg;

  //------------------------------------------------------------
  // widths
  //------------------------------------------------------------

  localparam int data_width  = 32;  // internal and external data word
  localparam int count_width = 2;   // up to four accesses per transfer

  //------------------------------------------------------------
  // size encoding
  //------------------------------------------------------------

  // same code for transfer size and bus size
  // code is log2 of the byte count, so a larger code is a wider size
  typedef enum logic [1:0]
  {
    size_8  = 2'b00,  // byte
    size_16 = 2'b01,  // halfword
    size_32 = 2'b10   // word
  } size_e;

  //------------------------------------------------------------
  // structs
  //------------------------------------------------------------

  // request sizes, sampled with valid_access
  typedef struct packed
  {
    size_e xfer_size;  // internal transfer size
    size_e bus_size;   // external bus width for this request
  } xfer_req_t;

  // registered view of the transfer in progress
  typedef struct packed
  {
    logic [count_width-1:0] num_access;  // accesses left after this one
    size_e                  bus_size;    // registered bus width
    size_e                  xfer_size;   // registered transfer size
  } access_state_t;

endpackage

`default_nettype wire

/* logic/smc_access_counter.sv */
/* access counter for the multiple access controller
   holds request sizes, counts external accesses down and flags the last one */

`timescale 1ns/100ps
`default_nettype none

module smc_access_counter
(
  input  wire                          sys_clk21,      // system clock
  input  wire                          n_sys_reset21,  // async reset, active low
  input  wire                          valid_access,   // new transfer strobe
  input  smc_mac_pkg::xfer_req_t       xfer_req,       // sizes, valid with strobe
  input  wire                          access_done,    // one external access finished
  output smc_mac_pkg::access_state_t   access_state,   // count and registered sizes
  output logic                         mac_done        // last (or only) access
);

  logic [smc_mac_pkg::count_width-1:0] load_count;  // accesses minus one

  //------------------------------------------------------------
  // access count from size ratio
  //------------------------------------------------------------

  // transfer bytes / bus bytes - 1, floored at zero
  always_comb
  begin
    case ({xfer_req.xfer_size, xfer_req.bus_size})
      {smc_mac_pkg::size_32, smc_mac_pkg::size_8}:
        load_count = smc_mac_pkg::count_width'(3);  // four byte accesses
      {smc_mac_pkg::size_32, smc_mac_pkg::size_16},
      {smc_mac_pkg::size_16, smc_mac_pkg::size_8}:
        load_count = smc_mac_pkg::count_width'(1);  // two accesses
      default:
        load_count = '0;  // bus wide enough, single access
    endcase
  end

  //------------------------------------------------------------
  // registered sizes and counter
  //------------------------------------------------------------

  always_ff @(posedge sys_clk21 or negedge n_sys_reset21)
  begin
    if (!n_sys_reset21)
    begin
      access_state.num_access <= '0;
      access_state.bus_size   <= smc_mac_pkg::size_8;
      access_state.xfer_size  <= smc_mac_pkg::size_8;
    end
    else if (valid_access)
    begin
      // new request wins over access_done, restarts any transfer in flight
      access_state.num_access <= load_count;
      access_state.bus_size   <= xfer_req.bus_size;
      access_state.xfer_size  <= xfer_req.xfer_size;
    end
    else if (access_done && !mac_done)
    begin
      // step to next access, hold at zero
      access_state.num_access <= access_state.num_access
                                 - smc_mac_pkg::count_width'(1);
    end
  end

  //------------------------------------------------------------
  // last access detect
  //------------------------------------------------------------

  // also high when idle, count sits at zero between transfers
  assign mac_done = (access_state.num_access == '0);

endmodule

`default_nettype wire

/* logic/smc_read_assembler.sv */
/* read data assembler for the multiple access controller
   collects partial bus reads into a word and replicates narrow transfers */

`timescale 1ns/100ps
`default_nettype none

module smc_read_assembler
(
  input  wire                                 sys_clk21,      // system clock
  input  wire                                 n_sys_reset21,  // async reset, active low
  input  smc_mac_pkg::access_state_t          access_state,   // count and sizes
  input  wire                                 latch_data,     // data_smc valid strobe
  input  wire [smc_mac_pkg::data_width-1:0]   data_smc,       // external read data
  output logic [smc_mac_pkg::data_width-1:0]  read_data       // word to internal bus
);

  logic [smc_mac_pkg::data_width-1:0] r_read_data;  // partial word store
  logic [smc_mac_pkg::data_width-1:0] store_next;   // store with current lanes merged
  logic [smc_mac_pkg::data_width-1:0] word_src;     // word before replication
  logic                               final_latch;  // last access data on the bus

  //------------------------------------------------------------
  // slot select for incoming lanes
  //------------------------------------------------------------

  // num_access picks the slot, msb part arrives first
  // lower slots are cleared, upper slots kept from earlier accesses
  always_comb
  begin
    case (access_state.bus_size)
      smc_mac_pkg::size_8:
      begin
        case (access_state.num_access)
          2'd3:    store_next = {data_smc[7:0], 24'h0};                    // byte 3
          2'd2:    store_next = {r_read_data[31:24], data_smc[7:0], 16'h0};
          2'd1:    store_next = {r_read_data[31:16], data_smc[7:0], 8'h0};
          default: store_next = {r_read_data[31:8], data_smc[7:0]};        // byte 0
        endcase
      end
      smc_mac_pkg::size_16:
      begin
        if (access_state.num_access[0])
          store_next = {data_smc[15:0], 16'h0};  // upper halfword
        else
          store_next = {r_read_data[31:16], data_smc[15:0]};
      end
      default:
        store_next = data_smc;  // full width bus, whole word in one go
    endcase
  end

  //------------------------------------------------------------
  // partial word register
  //------------------------------------------------------------

  always_ff @(posedge sys_clk21 or negedge n_sys_reset21)
  begin
    if (!n_sys_reset21)
      r_read_data <= '0;
    else if (latch_data)
      r_read_data <= store_next;  // takes lanes on edge after strobe
  end

  //------------------------------------------------------------
  // read word mux
  //------------------------------------------------------------

  // on the final strobe the merged word is used before it is stored
  assign final_latch = latch_data && (access_state.num_access == '0);

  // at count zero store_next is stored upper parts plus live low lanes
  assign word_src = final_latch ? store_next : r_read_data;

  always_comb
  begin
    if (latch_data && (access_state.bus_size == smc_mac_pkg::size_32))
    begin
      read_data = data_smc;  // wide bus, live data straight through
    end
    else
    begin
      case (access_state.xfer_size)
        smc_mac_pkg::size_8:
          read_data = {4{word_src[7:0]}};   // byte on every lane
        smc_mac_pkg::size_16:
          read_data = {2{word_src[15:0]}};  // halfword in both halves
        default:
          read_data = word_src;
      endcase
    end
  end

  // intermediate strobes show the stored word, not partial live data
  // r_read_data upper lanes may hold stale parts of an earlier transfer,
  // replication keeps them off the internal bus for narrow transfers

endmodule

`default_nettype wire

/* logic/smc_write_lane_select.sv */
/* write lane select for the multiple access controller
   puts the write data slice for the current access on the external bus */

`timescale 1ns/100ps
`default_nettype none

module smc_write_lane_select
(
  input  smc_mac_pkg::access_state_t          access_state,  // count and sizes
  input  wire [smc_mac_pkg::data_width-1:0]   write_data,    // held for whole transfer
  output logic [smc_mac_pkg::data_width-1:0]  smc_data       // to external bus
);

  //------------------------------------------------------------
  // lane mux
  //------------------------------------------------------------

  // slice index is num_access, so the msb part goes out first
  // narrow transfers sit in the low lanes of write_data
  always_comb
  begin
    case (access_state.bus_size)
      smc_mac_pkg::size_32:
        smc_data = write_data;  // single access
      smc_mac_pkg::size_16:
      begin
        if (access_state.num_access[0])
          smc_data = {16'h0, write_data[31:16]};  // first of two
        else
          smc_data = {16'h0, write_data[15:0]};
      end
      smc_mac_pkg::size_8:
      begin
        case (access_state.num_access)
          2'd3:    smc_data = {24'h0, write_data[31:24]};
          2'd2:    smc_data = {24'h0, write_data[23:16]};
          2'd1:    smc_data = {24'h0, write_data[15:8]};
          default: smc_data = {24'h0, write_data[7:0]};  // last byte
        endcase
      end
      default:
        smc_data = '0;  // unused size code, keep bus quiet
    endcase
  end

  // upper lanes forced low so the pads see no stray data

endmodule

`default_nettype wire

/* logic/smc_mac.sv */
/* multiple access controller top
   splits wide transfers into narrow external accesses, both directions */

`timescale 1ns/100ps
`default_nettype none

module smc_mac
(
  input  wire                                  sys_clk21,      // system clock
  input  wire                                  n_sys_reset21,  // async reset, active low
  input  wire                                  valid_access,   // new transfer strobe
  input  smc_mac_pkg::xfer_req_t               xfer_req,       // sizes with strobe
  input  wire                                  access_done,    // external access end
  input  wire                                  latch_data,     // read data valid
  input  wire [smc_mac_pkg::data_width-1:0]    data_smc,       // external read data
  input  wire [smc_mac_pkg::data_width-1:0]    write_data,     // internal write data
  output logic [smc_mac_pkg::count_width-1:0]  num_access,     // accesses still to come
  output logic                                 mac_done,       // last access
  output logic [smc_mac_pkg::data_width-1:0]   read_data,      // to internal bus
  output logic [smc_mac_pkg::data_width-1:0]   smc_data        // to external bus
);

  smc_mac_pkg::access_state_t access_state;  // shared by both data paths

  //------------------------------------------------------------
  // counter
  //------------------------------------------------------------

  smc_access_counter u_access_counter
  (
    .sys_clk21     (sys_clk21),
    .n_sys_reset21 (n_sys_reset21),
    .valid_access  (valid_access),
    .xfer_req      (xfer_req),
    .access_done   (access_done),
    .access_state  (access_state),
    .mac_done      (mac_done)
  );

  //------------------------------------------------------------
  // data paths
  //------------------------------------------------------------

  smc_read_assembler u_read_assembler
  (
    .sys_clk21     (sys_clk21),
    .n_sys_reset21 (n_sys_reset21),
    .access_state  (access_state),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .read_data     (read_data)
  );

  smc_write_lane_select u_write_lane_select
  (
    .access_state  (access_state),
    .write_data    (write_data),
    .smc_data      (smc_data)
  );

  assign num_access = access_state.num_access;  // count for the sequencer

endmodule

`default_nettype wire

/* verif/smc_mac_assertions.sv */
/* concurrent checks for the multiple access controller
   done decode, counter wrap and unused write lanes */

`timescale 1ns/100ps
`default_nettype none

module smc_mac_assertions
(
  input wire                                   sys_clk21,      // system clock
  input wire                                   n_sys_reset21,  // async reset, active low
  input wire                                   valid_access,   // new transfer strobe
  input wire [smc_mac_pkg::count_width-1:0]    num_access,     // accesses still to come
  input wire                                   mac_done,       // last access flag
  input wire smc_mac_pkg::access_state_t       access_state,   // registered sizes
  input wire [smc_mac_pkg::data_width-1:0]     smc_data        // external write lanes
);

  //------------------------------------------------------------
  // counter
  //------------------------------------------------------------

  // done flag is a pure decode of the count
  a_done_decode : assert property (@(posedge sys_clk21) disable iff (!n_sys_reset21)
    mac_done == (num_access == '0))
    else $error("mac_done does not follow num_access");

  // idle count holds, only a new request may load a high count
  a_no_wrap : assert property (@(posedge sys_clk21) disable iff (!n_sys_reset21)
    (num_access == '0 && !valid_access) |=> (num_access != 2'd3))
    else $error("num_access wrapped from 0 to 3 without valid_access");

  //------------------------------------------------------------
  // write lanes
  //------------------------------------------------------------

  a_lanes_8 : assert property (@(posedge sys_clk21) disable iff (!n_sys_reset21)
    (access_state.bus_size == smc_mac_pkg::size_8) |-> (smc_data[31:8] == '0))
    else $error("smc_data upper lanes active on 8 bit bus");

  a_lanes_16 : assert property (@(posedge sys_clk21) disable iff (!n_sys_reset21)
    (access_state.bus_size == smc_mac_pkg::size_16) |-> (smc_data[31:16] == '0))
    else $error("smc_data upper lanes active on 16 bit bus");

endmodule

bind smc_mac smc_mac_assertions u_mac_assertions
(
  .sys_clk21     (sys_clk21),
  .n_sys_reset21 (n_sys_reset21),
  .valid_access  (valid_access),
  .num_access    (num_access),
  .mac_done      (mac_done),
  .access_state  (access_state),
  .smc_data      (smc_data)
);

`default_nettype wire

/* verif/smc_mac_tb.sv */
/* testbench for the multiple access controller
   directed and random transfers checked against a size based model */

`timescale 1ns/100ps
`default_nettype none

module smc_mac_tb;

  typedef logic [smc_mac_pkg::data_width-1:0] word_t;

  logic                                 sys_clk21;
  logic                                 n_sys_reset21;
  logic                                 valid_access;
  smc_mac_pkg::xfer_req_t               xfer_req;
  logic                                 access_done;
  logic                                 latch_data;
  word_t                                data_smc;
  word_t                                write_data;
  logic [smc_mac_pkg::count_width-1:0]  num_access;
  logic                                 mac_done;
  word_t                                read_data;
  word_t                                smc_data;

  word_t read_parts [4];  // bus data per access with the msb part first
  int    mismatch_count;  // wrong values
  int    other_count;     // timeouts and the like

  smc_mac dut0
  (
    .sys_clk21     (sys_clk21),
    .n_sys_reset21 (n_sys_reset21),
    .valid_access  (valid_access),
    .xfer_req      (xfer_req),
    .access_done   (access_done),
    .latch_data    (latch_data),
    .data_smc      (data_smc),
    .write_data    (write_data),
    .num_access    (num_access),
    .mac_done      (mac_done),
    .read_data     (read_data),
    .smc_data      (smc_data)
  );

  initial
  begin
    sys_clk21 = 1'b0;
    forever #2 sys_clk21 = ~sys_clk21;  // 4 ns period
  end

  //------------------------------------------------------------
  // reference model
  //------------------------------------------------------------

  function automatic int size_bytes(input smc_mac_pkg::size_e size);
    case (size)
      smc_mac_pkg::size_8:  return 1;
      smc_mac_pkg::size_16: return 2;
      default:              return 4;
    endcase
  endfunction

  // transfer bytes over bus bytes with a floor of one
  function automatic int expected_accesses(input smc_mac_pkg::size_e xfer,
                                           input smc_mac_pkg::size_e bus);
    int n;
    n = size_bytes(xfer) / size_bytes(bus);
    if (n < 1)
      n = 1;
    return n;
  endfunction

  // slice picked by the remaining count on the low lanes
  function automatic word_t expected_lanes(input smc_mac_pkg::size_e bus, input word_t wdata,
                                           input int remaining);
    int    bits;
    word_t mask;
    bits = 8 * size_bytes(bus);
    if (bits == 32)
      return wdata;
    mask = (32'h1 << bits) - 32'h1;
    return (wdata >> (remaining * bits)) & mask;
  endfunction

  // joins the low lanes of each access so the first one ends up on top
  function automatic word_t assemble_read(input smc_mac_pkg::size_e xfer,
                                          input smc_mac_pkg::size_e bus);
    word_t word;
    int    bits;
    int    n;
    n = expected_accesses(xfer, bus);
    bits = 8 * size_bytes(bus);
    if (n == 1)
      return read_parts[0];  // one access covers it
    word = '0;
    for (int k = 0; k < n; k++)
      word = (word << bits) | (read_parts[k] & ((32'h1 << bits) - 32'h1));
    return word;
  endfunction

  function automatic word_t replicate(input smc_mac_pkg::size_e xfer, input word_t word);
    case (xfer)
      smc_mac_pkg::size_8:  return {4{word[7:0]}};
      smc_mac_pkg::size_16: return {2{word[15:0]}};
      default:              return word;
    endcase
  endfunction

  //------------------------------------------------------------
  // helpers
  //------------------------------------------------------------

  task automatic report_mismatch(input string test_name, input string what,
                                 input word_t expected, input word_t actual);
    mismatch_count++;
    $display("mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
  endtask

  task automatic load_parts(input word_t p0, input word_t p1, input word_t p2, input word_t p3);
    read_parts[0] = p0;
    read_parts[1] = p1;
    read_parts[2] = p2;
    read_parts[3] = p3;
  endtask

  // one request then an access per cycle until mac_done shows the last one
  task automatic run_transfer(input string test_name, input smc_mac_pkg::size_e xfer,
                              input smc_mac_pkg::size_e bus, input logic do_read);
    int                                  n;
    int                                  k;
    logic [smc_mac_pkg::count_width-1:0] exp_count;
    word_t                               exp_word;
    word_t                               exp_live;
    word_t                               exp_lanes;
    n = expected_accesses(xfer, bus);
    exp_word = replicate(xfer, assemble_read(xfer, bus));
    @(posedge sys_clk21);
    valid_access       <= 1'b1;
    xfer_req.xfer_size <= xfer;
    xfer_req.bus_size  <= bus;
    @(posedge sys_clk21);
    valid_access <= 1'b0;
    k = 0;
    forever
    begin
      access_done <= 1'b1;
      latch_data  <= do_read;
      data_smc    <= read_parts[k];
      @(negedge sys_clk21);  // outputs settled
      exp_count = 2'(n - 1 - k);
      exp_lanes = expected_lanes(bus, write_data, n - 1 - k);
      if (num_access !== exp_count)
        report_mismatch(test_name, "num_access", 32'(exp_count), 32'(num_access));
      if (mac_done !== (k == n - 1))
        report_mismatch(test_name, "mac_done", 32'(k == n - 1), 32'(mac_done));
      if (smc_data !== exp_lanes)
        report_mismatch(test_name, "smc_data", exp_lanes, smc_data);
      if (do_read && (k == n - 1))
      begin
        if (bus == smc_mac_pkg::size_32)
          exp_live = read_parts[k];  // wide bus passes through
        else
          exp_live = exp_word;
        if (read_data !== exp_live)
          report_mismatch(test_name, "read_data final", exp_live, read_data);
      end
      if (mac_done)
        break;
      k++;
      if (k >= 4)
      begin
        other_count++;
        $display("%s: mac_done did not rise within 4 accesses", test_name);
        break;
      end
      @(posedge sys_clk21);
    end
    @(posedge sys_clk21);
    access_done <= 1'b0;  // last strobe at count 0 was ignored
    latch_data  <= 1'b0;
    @(negedge sys_clk21);
    if (num_access !== '0)
      report_mismatch(test_name, "num_access idle", 32'h0, 32'(num_access));
    if (do_read && read_data !== exp_word)
      report_mismatch(test_name, "read_data held", exp_word, read_data);
  endtask

  //------------------------------------------------------------
  // tests
  //------------------------------------------------------------

  task automatic check_after_reset();
    @(negedge sys_clk21);
    if (mac_done !== 1'b1)
      report_mismatch("after_reset", "mac_done", 32'h1, 32'(mac_done));
    if (num_access !== '0)
      report_mismatch("after_reset", "num_access", 32'h0, 32'(num_access));
    if (read_data !== '0)
      report_mismatch("after_reset", "read_data", 32'h0, read_data);
  endtask

  task automatic write_word_on_byte_bus();
    @(posedge sys_clk21);
    write_data <= 32'hA1B2_C3D4;
    load_parts('0, '0, '0, '0);
    run_transfer("write_32_on_8", smc_mac_pkg::size_32, smc_mac_pkg::size_8, 1'b0);
  endtask

  // junk in the upper lanes must not reach the word
  task automatic read_word_on_narrow_bus();
    load_parts(32'h5A5A_5A12, 32'hA5A5_A534, 32'hFFFF_FF56, 32'h0000_0078);
    run_transfer("read_32_on_8", smc_mac_pkg::size_32, smc_mac_pkg::size_8, 1'b1);
    load_parts(32'hDEAD_9ABC, 32'hBEEF_DEF0, '0, '0);
    run_transfer("read_32_on_16", smc_mac_pkg::size_32, smc_mac_pkg::size_16, 1'b1);
  endtask

  task automatic read_narrow_transfers();
    load_parts(32'h0000_77C3, 32'h1111_225E, '0, '0);
    run_transfer("read_16_on_8", smc_mac_pkg::size_16, smc_mac_pkg::size_8, 1'b1);
    load_parts(32'hFFFF_FF7B, '0, '0, '0);
    run_transfer("read_8_on_8", smc_mac_pkg::size_8, smc_mac_pkg::size_8, 1'b1);
    load_parts(32'h1122_3344, '0, '0, '0);
    run_transfer("read_8_on_32", smc_mac_pkg::size_8, smc_mac_pkg::size_32, 1'b1);
  endtask

  // every transfer size on every bus size
  task automatic run_random_pairs();
    for (int x = 0; x < 3; x++)
    begin
      for (int b = 0; b < 3; b++)
      begin
        @(posedge sys_clk21);
        write_data <= $urandom;
        load_parts($urandom, $urandom, $urandom, $urandom);
        run_transfer($sformatf("random_x%0d_b%0d", x, b), smc_mac_pkg::size_e'(x),
                     smc_mac_pkg::size_e'(b), 1'b1);
      end
    end
  endtask

  //------------------------------------------------------------
  // main sequence and watchdog
  //------------------------------------------------------------

  initial
  begin
    mismatch_count         = 0;
    other_count            = 0;
    n_sys_reset21          = 1'b0;
    valid_access           = 1'b0;
    xfer_req.xfer_size     = smc_mac_pkg::size_8;
    xfer_req.bus_size      = smc_mac_pkg::size_8;
    access_done            = 1'b0;
    latch_data             = 1'b0;
    data_smc               = '0;
    write_data             = '0;
    load_parts('0, '0, '0, '0);
    void'($urandom(27));
    repeat (3) @(posedge sys_clk21);
    n_sys_reset21 <= 1'b1;  // out of reset after 3 cycles
    check_after_reset();
    write_word_on_byte_bus();
    read_word_on_narrow_bus();
    read_narrow_transfers();
    run_random_pairs();
    @(posedge sys_clk21);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count + other_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  initial
  begin
    repeat (5000) @(posedge sys_clk21);
    $display("simulation did not finish in 5000 cycles");
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* smc_mac.f */
logic/smc_mac_pkg.sv
logic/smc_access_counter.sv
logic/smc_read_assembler.sv
logic/smc_write_lane_select.sv
logic/smc_mac.sv
verif/smc_mac_assertions.sv
verif/smc_mac_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the smc_mac testbench with Verilator
# exit status is nonzero when the run reports a failure

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module smc_mac_tb -f smc_mac.f -o smc_mac_sim \
  || { echo "compile failed"; exit 1; }

./obj_dir/smc_mac_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "Test FAILED" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test OK" sim.log && { echo "PASS"; exit 0; }
echo "no result found in sim.log"
exit 1
